/* chol_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module chol_assertions (
    input logic clk,
    input logic rst,
    input logic in_req,
    input logic in_ack,
    input logic l_valid,
    input logic sqrt_req,
    input logic sqrt_ack,
    input logic div_req,
    input logic div_ack
);

    int fail_count = 0;   // Failed assertions so far

    // ------------------------------------------------------------
    // Unit handshakes
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst) $rose(sqrt_ack) |-> sqrt_req)
        else begin
            fail_count++;
            $error("sqrt_ack rose without sqrt_req");
        end
    assert property (@(posedge clk) disable iff (rst) $rose(div_ack) |-> div_req)
        else begin
            fail_count++;
            $error("div_ack rose without div_req");
        end

    // Request held until acknowledged
    assert property (@(posedge clk) disable iff (rst) sqrt_req && !sqrt_ack |=> sqrt_req)
        else begin
            fail_count++;
            $error("sqrt_req dropped before sqrt_ack");
        end
    assert property (@(posedge clk) disable iff (rst) div_req && !div_ack |=> div_req)
        else begin
            fail_count++;
            $error("div_req dropped before div_ack");
        end

    // ------------------------------------------------------------
    // Top level
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst) l_valid |=> !l_valid)
        else begin
            fail_count++;
            $error("l_valid held longer than one cycle");
        end
    assert property (@(posedge clk) disable iff (rst) $rose(in_ack) |-> $past(in_req))
        else begin
            fail_count++;
            $error("in_ack rose without in_req");
        end

endmodule

bind chol_top chol_assertions chol_assertions_inst (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .l_valid  (l_valid),
    .sqrt_req (sqrt_req),
    .sqrt_ack (sqrt_ack),
    .div_req  (div_req),
    .div_ack  (div_ack)
);

`default_nettype wire

/* chol_div.sv */
`timescale 1ns/1ps
`default_nettype none
`include "chol_macros.svh"

module chol_div (
    input  logic               clk,
    input  logic               rst,
    input  logic               div_req,
    input  chol_pkg::div_req_t div_arg,
    output logic               div_ack,
    output chol_pkg::fix_t     div_res
);

    localparam int W  = `CHOL_W;
    localparam int QW = `CHOL_DIV_ITER;  // Scaled dividend / quotient bits
    localparam int CW = $clog2(`CHOL_DIV_ITER + 1);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_RUN  = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]     state;
    logic [CW-1:0]  cnt;
    logic [QW-1:0]  num;      // Dividend shifts out, quotient shifts in
    logic [W-1:0]   rem;
    logic [W-1:0]   den;
    logic           neg;      // Operand signs differ
    logic [W:0]     rem_sh;
    logic [W-1:0]   dvd_mag;
    logic [W-1:0]   dvs_mag;
    chol_pkg::fix_t q_mag;

    // Magnitudes, -2^31 maps to 2^31 unsigned
    assign dvd_mag = div_arg.dividend[W-1] ? W'(-div_arg.dividend) : W'(div_arg.dividend);
    assign dvs_mag = div_arg.divisor[W-1] ? W'(-div_arg.divisor) : W'(div_arg.divisor);

    assign rem_sh = {rem, num[QW-1]};

    // Sign applied to the magnitude, so truncation is toward zero
    assign q_mag   = num[W-1:0];
    assign div_res = neg ? -q_mag : q_mag;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            div_ack <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (div_req) begin
                        num   <= {dvd_mag, {`CHOL_FRAC{1'b0}}};
                        den   <= dvs_mag;
                        neg   <= div_arg.dividend[W-1] ^ div_arg.divisor[W-1];
                        rem   <= '0;
                        cnt   <= '0;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (rem_sh >= {1'b0, den}) begin
                        rem <= W'(rem_sh - {1'b0, den});
                        num <= {num[QW-2:0], 1'b1};
                    end else begin
                        rem <= W'(rem_sh);
                        num <= {num[QW-2:0], 1'b0};
                    end
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(QW - 1)) begin
                        div_ack <= 1'b1;
                        state   <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (!div_req) begin
                        div_ack <= 1'b0;  // Result held until here
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* chol_macros.svh */
`ifndef CHOL_MACROS_SVH
`define CHOL_MACROS_SVH

// Matrix order, 2 to 5
`define CHOL_N 3

// Signed Q16.16 word
`define CHOL_W    32
`define CHOL_FRAC 16

// Lower triangle element count
`define CHOL_NELEM ((`CHOL_N * (`CHOL_N + 1)) / 2)

// One root bit per iteration over the 48-bit scaled radicand
`define CHOL_SQRT_ITER 24

// One quotient bit per iteration over the 48-bit scaled dividend
`define CHOL_DIV_ITER 48

`endif

/* chol_pkg.sv */
`default_nettype none
`include "chol_macros.svh"

package chol_pkg;

    // ------------------------------------------------------------
    // Fixed point word
    // ------------------------------------------------------------
    typedef logic signed [`CHOL_W-1:0] fix_t;

    // Lower triangle, row-major: e[0]=a11, e[1]=a21, e[2]=a22, e[3]=a31 ...
    typedef struct packed {
        fix_t [`CHOL_NELEM-1:0] e;
    } tri_t;

    // ------------------------------------------------------------
    // Request payloads for the iterative units
    // ------------------------------------------------------------
    typedef struct packed {
        fix_t radicand;   // Must be positive
    } sqrt_req_t;

    typedef struct packed {
        fix_t dividend;
        fix_t divisor;
    } div_req_t;

endpackage

`default_nettype wire

/* chol_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "chol_macros.svh"

module chol_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_req,
    input  chol_pkg::tri_t      a_in,
    output logic                in_ack,
    output chol_pkg::tri_t      l_out,
    output logic                l_valid,
    output logic                not_pd,
    output logic                sqrt_req,
    output chol_pkg::sqrt_req_t sqrt_arg,
    input  logic                sqrt_ack,
    input  chol_pkg::fix_t      sqrt_res,
    output logic                div_req,
    output chol_pkg::div_req_t  div_arg,
    input  logic                div_ack,
    input  chol_pkg::fix_t      div_res
);

    localparam int N  = `CHOL_N;
    localparam int IW = $clog2(`CHOL_N);      // Row / column index width
    localparam int EW = $clog2(`CHOL_NELEM);  // Element index width

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_LOAD  = 3'd1;
    localparam logic [2:0] S_ACC   = 3'd2;
    localparam logic [2:0] S_SQRT  = 3'd3;
    localparam logic [2:0] S_DIV   = 3'd4;
    localparam logic [2:0] S_WRITE = 3'd5;
    localparam logic [2:0] S_DONE  = 3'd6;

    logic [2:0]    state;
    logic [IW-1:0] i;        // Row
    logic [IW-1:0] j;        // Column
    logic [IW-1:0] k;        // Inner product term
    logic          fail_q;   // Non-positive pivot seen

    chol_pkg::tri_t store;   // Holds A, overwritten in place by L
    chol_pkg::fix_t acc;
    chol_pkg::fix_t res_q;   // Unit result waiting for release of ack

    chol_pkg::fix_t              op_a;
    chol_pkg::fix_t              op_b;
    chol_pkg::fix_t              prod_fix;
    logic signed [2*`CHOL_W-1:0] prod;

    // Position of (r, c) in the packed triangle
    function automatic logic [EW-1:0] idx(input logic [IW-1:0] r, input logic [IW-1:0] c);
        int lin;
        lin = int'(r) * (int'(r) + 1) / 2 + int'(c);
        return EW'(lin);
    endfunction

    // ------------------------------------------------------------
    // Multiply-subtract operand path, l_ik * l_jk
    // ------------------------------------------------------------
    always_comb begin
        op_a     = store.e[idx(i, k)];
        op_b     = store.e[idx(j, k)];
        prod     = op_a * op_b;
        prod_fix = prod[`CHOL_W+`CHOL_FRAC-1:`CHOL_FRAC];  // Q32.32 back to Q16.16
    end

    // Arguments are held stable by the registers behind them
    assign sqrt_arg.radicand = acc;
    assign div_arg.dividend  = acc;
    assign div_arg.divisor   = store.e[idx(j, j)];

    // ------------------------------------------------------------
    // Column walk
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            i        <= '0;
            j        <= '0;
            k        <= '0;
            fail_q   <= 1'b0;
            in_ack   <= 1'b0;
            sqrt_req <= 1'b0;
            div_req  <= 1'b0;
            l_valid  <= 1'b0;
            not_pd   <= 1'b0;
            l_out    <= '0;
        end else begin
            l_valid <= 1'b0;
            if (in_ack && !in_req) begin
                in_ack <= 1'b0;   // Four-phase return to zero
            end

            case (state)
                S_IDLE: begin
                    if (in_req && !in_ack) begin
                        store  <= a_in;
                        in_ack <= 1'b1;
                        i      <= '0;
                        j      <= '0;
                        fail_q <= 1'b0;
                        state  <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    acc   <= store.e[idx(i, j)];
                    k     <= '0;
                    state <= S_ACC;
                end
                S_ACC: begin
                    if (k == j) begin
                        if (i != j) begin
                            div_req <= 1'b1;
                            state   <= S_DIV;
                        end else if (acc <= 0) begin
                            // Clear column j onward, earlier columns stay
                            for (int r = 0; r < N; r++) begin
                                for (int c = 0; c <= r; c++) begin
                                    if (c >= int'(j)) begin
                                        store.e[idx(IW'(r), IW'(c))] <= '0;
                                    end
                                end
                            end
                            fail_q <= 1'b1;
                            state  <= S_DONE;
                        end else begin
                            sqrt_req <= 1'b1;
                            state    <= S_SQRT;
                        end
                    end else begin
                        acc <= acc - prod_fix;  // Wraps to 32 bits
                        k   <= k + 1'b1;
                    end
                end
                S_SQRT: begin
                    if (sqrt_ack) begin
                        res_q    <= sqrt_res;
                        sqrt_req <= 1'b0;
                        state    <= S_WRITE;
                    end
                end
                S_DIV: begin
                    if (div_ack) begin
                        res_q   <= div_res;
                        div_req <= 1'b0;
                        state   <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    // Wait for both acks low before any new request
                    if (!sqrt_ack && !div_ack) begin
                        store.e[idx(i, j)] <= res_q;
                        if (i != IW'(N - 1)) begin
                            i     <= i + 1'b1;
                            state <= S_LOAD;
                        end else if (j != IW'(N - 1)) begin
                            j     <= j + 1'b1;
                            i     <= j + 1'b1;   // Next diagonal
                            state <= S_LOAD;
                        end else begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    l_out   <= store;
                    not_pd  <= fail_q;
                    l_valid <= 1'b1;
                    state   <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* chol_sqrt.sv */
`timescale 1ns/1ps
`default_nettype none
`include "chol_macros.svh"

module chol_sqrt (
    input  logic                clk,
    input  logic                rst,
    input  logic                sqrt_req,
    input  chol_pkg::sqrt_req_t sqrt_arg,
    output logic                sqrt_ack,
    output chol_pkg::fix_t      sqrt_res
);

    localparam int RW = `CHOL_SQRT_ITER;      // Root bits
    localparam int DW = 2 * `CHOL_SQRT_ITER;  // Scaled radicand bits
    localparam int CW = $clog2(`CHOL_SQRT_ITER + 1);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_RUN  = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]    state;
    logic [CW-1:0] cnt;
    logic [DW-1:0] data;     // Radicand bits, consumed two at a time
    logic [RW+3:0] rem;
    logic [RW-1:0] root;
    logic [RW+3:0] rem_sh;
    logic [RW+3:0] trial;

    // Restoring step
    assign rem_sh = {rem[RW+1:0], data[DW-1:DW-2]};
    assign trial  = {2'b00, root, 2'b01};

    assign sqrt_res = chol_pkg::fix_t'({{(`CHOL_W - RW){1'b0}}, root});

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            cnt      <= '0;
            sqrt_ack <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (sqrt_req) begin
                        data  <= {sqrt_arg.radicand, {`CHOL_FRAC{1'b0}}};  // x * 2^16
                        rem   <= '0;
                        root  <= '0;
                        cnt   <= '0;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    data <= {data[DW-3:0], 2'b00};
                    if (rem_sh >= trial) begin
                        rem  <= rem_sh - trial;
                        root <= {root[RW-2:0], 1'b1};
                    end else begin
                        rem  <= rem_sh;
                        root <= {root[RW-2:0], 1'b0};
                    end
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(RW - 1)) begin
                        sqrt_ack <= 1'b1;  // Root complete with this step
                        state    <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (!sqrt_req) begin
                        sqrt_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* chol_top.sv */
`timescale 1ns/1ps
`default_nettype none

module chol_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_req,
    input  chol_pkg::tri_t a_in,
    output logic           in_ack,
    output chol_pkg::tri_t l_out,
    output logic           l_valid,
    output logic           not_pd
);

    // Sequencer to unit handshakes
    logic                sqrt_req;
    logic                sqrt_ack;
    chol_pkg::sqrt_req_t sqrt_arg;
    chol_pkg::fix_t      sqrt_res;

    logic                div_req;
    logic                div_ack;
    chol_pkg::div_req_t  div_arg;
    chol_pkg::fix_t      div_res;

    chol_sequencer seq_inst (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .a_in     (a_in),
        .in_ack   (in_ack),
        .l_out    (l_out),
        .l_valid  (l_valid),
        .not_pd   (not_pd),
        .sqrt_req (sqrt_req),
        .sqrt_arg (sqrt_arg),
        .sqrt_ack (sqrt_ack),
        .sqrt_res (sqrt_res),
        .div_req  (div_req),
        .div_arg  (div_arg),
        .div_ack  (div_ack),
        .div_res  (div_res)
    );

    chol_sqrt sqrt_inst (
        .clk      (clk),
        .rst      (rst),
        .sqrt_req (sqrt_req),
        .sqrt_arg (sqrt_arg),
        .sqrt_ack (sqrt_ack),
        .sqrt_res (sqrt_res)
    );

    chol_div div_inst (
        .clk     (clk),
        .rst     (rst),
        .div_req (div_req),
        .div_arg (div_arg),
        .div_ack (div_ack),
        .div_res (div_res)
    );

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
chol_pkg.sv
chol_sqrt.sv
chol_div.sv
chol_sequencer.sv
chol_top.sv
chol_assertions.sv
tb_chol.sv

/* tb_chol.sv */
`timescale 1ns/1ps
`default_nettype none
`include "chol_macros.svh"

module tb_chol;

    localparam int N              = `CHOL_N;
    localparam int NELEM          = `CHOL_NELEM;
    localparam int ONE            = 1 << `CHOL_FRAC;
    localparam int N_RANDOM       = 30;
    localparam int TIMEOUT_CYCLES = 40 * 400 + 200;

    logic           clk;
    logic           rst;
    logic           in_req;
    chol_pkg::tri_t a_in;
    logic           in_ack;
    chol_pkg::tri_t l_out;
    logic           l_valid;
    logic           not_pd;

    chol_pkg::tri_t exp_l_q[$];    // Expected factors, in acceptance order
    logic           exp_npd_q[$];
    chol_pkg::tri_t exp_l;
    logic           exp_npd;

    int accepted     = 0;
    int results_seen = 0;
    int data_errors  = 0;
    int proto_errors = 0;
    int cycles       = 0;

    chol_top chol_top_inst (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .a_in    (a_in),
        .in_ack  (in_ack),
        .l_out   (l_out),
        .l_valid (l_valid),
        .not_pd  (not_pd)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic int tri_pos(input int r, input int c);
        return r * (r + 1) / 2 + c;
    endfunction

    function automatic chol_pkg::fix_t mul_sub(input chol_pkg::fix_t c, input chol_pkg::fix_t a,
                                               input chol_pkg::fix_t b);
        longint p;
        p = (longint'(a) * longint'(b)) >>> `CHOL_FRAC;
        return chol_pkg::fix_t'(longint'(c) - p);  // Wraps to 32 bits
    endfunction

    // Largest r with r*r <= x * 2^16, by binary search
    function automatic chol_pkg::fix_t fix_sqrt(input chol_pkg::fix_t x);
        longint v;
        longint lo;
        longint hi;
        longint mid;
        v  = longint'(x) << `CHOL_FRAC;
        lo = 0;
        hi = 64'd1 << 24;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= v) lo = mid;
            else hi = mid - 1;
        end
        return chol_pkg::fix_t'(lo);
    endfunction

    function automatic chol_pkg::fix_t fix_div(input chol_pkg::fix_t n, input chol_pkg::fix_t d);
        longint q;
        q = (longint'(n) * ONE) / longint'(d);  // Truncates toward zero
        return chol_pkg::fix_t'(q);
    endfunction

    function automatic chol_pkg::tri_t chol_ref(input chol_pkg::tri_t a, output logic npd);
        chol_pkg::tri_t l;
        chol_pkg::fix_t d;
        l   = '0;   // Elements never reached stay zero
        npd = 1'b0;
        for (int j = 0; j < N; j++) begin
            if (!npd) begin
                d = a.e[tri_pos(j, j)];
                for (int k = 0; k < j; k++) begin
                    d = mul_sub(d, l.e[tri_pos(j, k)], l.e[tri_pos(j, k)]);
                end
                if (d <= 0) begin
                    npd = 1'b1;
                end else begin
                    l.e[tri_pos(j, j)] = fix_sqrt(d);
                    for (int i = j + 1; i < N; i++) begin
                        d = a.e[tri_pos(i, j)];
                        for (int k = 0; k < j; k++) begin
                            d = mul_sub(d, l.e[tri_pos(i, k)], l.e[tri_pos(j, k)]);
                        end
                        l.e[tri_pos(i, j)] = fix_div(d, l.e[tri_pos(j, j)]);
                    end
                end
            end
        end
        return l;
    endfunction

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic chol_pkg::tri_t random_factor();
        chol_pkg::tri_t l;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                if (i == j) l.e[tri_pos(i, j)] = ONE + int'($urandom % (3 * ONE));    // [1, 4)
                else l.e[tri_pos(i, j)] = int'($urandom % (4 * ONE)) - 2 * ONE;      // [-2, 2)
            end
        end
        return l;
    endfunction

    // A = L * L^T, lower triangle only
    function automatic chol_pkg::tri_t build_spd(input chol_pkg::tri_t l);
        chol_pkg::tri_t a;
        longint         s;
        chol_pkg::fix_t x;
        chol_pkg::fix_t y;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                s = 0;
                for (int k = 0; k <= j; k++) begin
                    x = l.e[tri_pos(i, k)];
                    y = l.e[tri_pos(j, k)];
                    s += longint'(x) * longint'(y);
                end
                a.e[tri_pos(i, j)] = chol_pkg::fix_t'(s >>> `CHOL_FRAC);
            end
        end
        return a;
    endfunction

    function automatic chol_pkg::tri_t identity();
        chol_pkg::tri_t a;
        a = '0;
        for (int r = 0; r < N; r++) a.e[tri_pos(r, r)] = ONE;
        return a;
    endfunction

    // Four-phase input handshake, returns once in_ack has fallen
    task automatic send_matrix(input chol_pkg::tri_t a, input chol_pkg::tri_t l,
                               input logic npd);
        @(posedge clk);
        #2;
        a_in   = a;
        in_req = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        if (results_seen != accepted) begin
            proto_errors++;
            $display("Matrix %0d was accepted before the previous result was delivered",
                     accepted);
        end
        exp_l_q.push_back(l);
        exp_npd_q.push_back(npd);
        accepted++;
        @(posedge clk);
        #2;
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic wait_results(input int n);
        while (results_seen < n) @(negedge clk);
    endtask

    task automatic run_checked(input chol_pkg::tri_t a);
        chol_pkg::tri_t l;
        logic           npd;
        l = chol_ref(a, npd);
        send_matrix(a, l, npd);
        wait_results(accepted);
    endtask

    // ------------------------------------------------------------
    // Compare on each result, sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst && l_valid) begin
            if (exp_l_q.size() == 0) begin
                proto_errors++;
                $display("l_valid pulsed with no matrix outstanding");
            end else begin
                exp_l   = exp_l_q.pop_front();
                exp_npd = exp_npd_q.pop_front();
                for (int n = 0; n < NELEM; n++) begin
                    if (l_out.e[n] !== exp_l.e[n]) begin
                        data_errors++;
                        $display("Error: l_out.e[%0d] is %h, expected %h (result %0d)",
                                 n, l_out.e[n], exp_l.e[n], results_seen);
                    end
                end
                if (not_pd !== exp_npd) begin
                    data_errors++;
                    $display("Error: not_pd is %h, expected %h (result %0d)",
                             not_pd, exp_npd, results_seen);
                end
            end
            results_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycles, results_seen, accepted);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        chol_pkg::tri_t a;
        chol_pkg::tri_t b;
        chol_pkg::tri_t l;
        chol_pkg::tri_t lb;
        logic           npd;
        logic           npd_b;

        void'($urandom(32'h700d));
        rst    = 1'b1;
        in_req = 1'b0;
        a_in   = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // Identity gives identity
        a = identity();
        send_matrix(a, a, 1'b0);
        wait_results(accepted);

        // Perfect squares on the diagonal
        a = '0;
        l = '0;
        for (int r = 0; r < N; r++) begin
            a.e[tri_pos(r, r)] = (r + 2) * (r + 2) * ONE;
            l.e[tri_pos(r, r)] = (r + 2) * ONE;
        end
        send_matrix(a, l, 1'b0);
        wait_results(accepted);

        repeat (N_RANDOM) run_checked(build_spd(random_factor()));

        // Zero pivot in column 2
        a = identity();
        a.e[tri_pos(0, 0)] = 4 * ONE;
        a.e[tri_pos(1, 0)] = 2 * ONE;
        run_checked(a);

        // Negative pivot in the last column
        a = identity();
        a.e[tri_pos(N - 1, N - 1)] = -ONE;
        run_checked(a);

        // Second matrix offered while the first is running
        a  = build_spd(random_factor());
        b  = build_spd(random_factor());
        l  = chol_ref(a, npd);
        lb = chol_ref(b, npd_b);
        send_matrix(a, l, npd);
        send_matrix(b, lb, npd_b);
        wait_results(accepted);

        repeat (4) @(posedge clk);
        $display("Results %0d, data errors %0d, protocol errors %0d, assertion failures %0d",
                 results_seen, data_errors, proto_errors,
                 chol_top_inst.chol_assertions_inst.fail_count);
        if (data_errors == 0 && proto_errors == 0 &&
            chol_top_inst.chol_assertions_inst.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
